// ==== src/axi_sram_defines.svh ====
`ifndef AXI_SRAM_DEFINES_SVH
`define AXI_SRAM_DEFINES_SVH

// AXI byte address width
`define AXI_ADDR_WIDTH 16

// One 16-bit SRAM word per beat
`define AXI_DATA_WIDTH 16

`define AXI_ID_WIDTH 4

`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

// Word address into the SRAM, byte lane bit dropped
`define SRAM_ADDR_WIDTH (`AXI_ADDR_WIDTH - 1)

`endif

// ==== src/axi_sram_pkg.sv ====
package axi_sram_pkg;

  // Burst type as carried on AWBURST and ARBURST
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // Only the responses this slave can return
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // Phases of a single SRAM word access
  typedef enum logic [1:0] {
    IO_IDLE    = 2'b00,
    IO_SETUP   = 2'b01,
    IO_STROBE  = 2'b10,
    IO_RECOVER = 2'b11
  } sram_phase_e;

endpackage

// ==== src/axi_burst_addr.sv ====
`timescale 1ns/10ps
`include "axi_sram_defines.svh"

module axi_burst_addr (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load,
  input  logic                          next,
  input  logic [`AXI_ADDR_WIDTH-1:0]    start_addr,
  input  logic [7:0]                    len,
  input  logic [2:0]                    size,
  input  axi_sram_pkg::axi_burst_e      burst,
  output logic [`SRAM_ADDR_WIDTH-1:0]   word_addr
);

  localparam int AW = `AXI_ADDR_WIDTH;
  localparam int LSB = $clog2(`AXI_STRB_WIDTH);

  logic [AW-1:0]            addr_q;
  logic [AW-1:0]            wrap_mask_q;
  logic [2:0]               size_q;
  axi_sram_pkg::axi_burst_e burst_q;
  logic [AW-1:0]            addr_incr;
  logic [AW-1:0]            addr_nxt;

  assign addr_incr = addr_q + (AW'(1) << size_q);

  always_comb begin
    case (burst_q)
      axi_sram_pkg::BURST_FIXED: addr_nxt = addr_q;
      // Upper bits stay put, the step rolls over inside the wrap window
      axi_sram_pkg::BURST_WRAP:  addr_nxt = (addr_q & ~wrap_mask_q) | (addr_incr & wrap_mask_q);
      default:                   addr_nxt = addr_incr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q      <= '0;
      wrap_mask_q <= '0;
      size_q      <= '0;
      burst_q     <= axi_sram_pkg::BURST_INCR;
    end else if (load) begin
      addr_q      <= start_addr;
      size_q      <= size;
      // Window is the total burst size in bytes
      wrap_mask_q <= ((AW'(len) + AW'(1)) << size) - AW'(1);
      // Reserved code behaves as INCR
      if (burst == axi_sram_pkg::BURST_FIXED || burst == axi_sram_pkg::BURST_WRAP) begin
        burst_q <= burst;
      end else begin
        burst_q <= axi_sram_pkg::BURST_INCR;
      end
    end else if (next) begin
      addr_q <= addr_nxt;
    end
  end

  assign word_addr = addr_q[AW-1:LSB];

endmodule

// ==== src/axi_sram_ctrl.sv ====
`timescale 1ns/10ps
`include "axi_sram_defines.svh"

module axi_sram_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          s_axi_awvalid,
  input  logic [`AXI_ID_WIDTH-1:0]      s_axi_awid,
  input  logic [7:0]                    s_axi_awlen,
  input  logic [2:0]                    s_axi_awsize,
  output logic                          s_axi_awready,
  input  logic                          s_axi_wvalid,
  input  logic [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
  input  logic [`AXI_STRB_WIDTH-1:0]    s_axi_wstrb,
  input  logic                          s_axi_wlast,
  output logic                          s_axi_wready,
  output logic                          s_axi_bvalid,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_bid,
  output logic [1:0]                    s_axi_bresp,
  input  logic                          s_axi_bready,

  input  logic                          s_axi_arvalid,
  input  logic [`AXI_ID_WIDTH-1:0]      s_axi_arid,
  input  logic [7:0]                    s_axi_arlen,
  input  logic [2:0]                    s_axi_arsize,
  output logic                          s_axi_arready,
  output logic                          s_axi_rvalid,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_rid,
  output logic [`AXI_DATA_WIDTH-1:0]    s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rlast,
  input  logic                          s_axi_rready,

  output logic                          wr_load,
  output logic                          wr_next,
  input  logic [`SRAM_ADDR_WIDTH-1:0]   wr_word_addr,
  output logic                          rd_load,
  output logic                          rd_next,
  input  logic [`SRAM_ADDR_WIDTH-1:0]   rd_word_addr,

  output logic                          sram_req,
  output logic                          sram_we,
  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_addr,
  output logic [`AXI_DATA_WIDTH-1:0]    sram_wdata,
  output logic [`AXI_STRB_WIDTH-1:0]    sram_be,
  input  logic                          sram_done,
  input  logic [`AXI_DATA_WIDTH-1:0]    sram_rdata
);

  localparam int LSB = $clog2(`AXI_STRB_WIDTH);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_BEAT,
    ST_WR_WAIT,
    ST_WR_RESP,
    ST_RD_ISSUE,
    ST_RD_WAIT,
    ST_RD_DATA
  } state_e;

  state_e                     state;
  logic                       last_wr;
  logic [7:0]                 count;
  logic [7:0]                 len_q;
  logic [`AXI_ID_WIDTH-1:0]   id_q;
  logic                       err_q;
  logic                       last_q;
  logic [`AXI_DATA_WIDTH-1:0] rdata_q;
  logic                       wr_win;
  logic                       rd_win;
  logic                       aw_xfer;
  logic                       ar_xfer;
  logic                       w_xfer;
  logic                       w_last;

  // Write wins unless a read is also waiting and write went last
  assign wr_win = s_axi_awvalid && (!s_axi_arvalid || !last_wr);
  assign rd_win = s_axi_arvalid && !wr_win;

  assign s_axi_awready = (state == ST_IDLE) && wr_win;
  assign s_axi_arready = (state == ST_IDLE) && rd_win;

  assign aw_xfer = s_axi_awvalid && s_axi_awready;
  assign ar_xfer = s_axi_arvalid && s_axi_arready;
  assign w_xfer  = s_axi_wvalid && s_axi_wready;
  assign w_last  = s_axi_wlast || (count == len_q);

  assign wr_load = aw_xfer;
  assign rd_load = ar_xfer;
  // Address of the current beat is already captured when the generator steps
  assign wr_next = w_xfer;
  assign rd_next = (state == ST_RD_ISSUE);

  assign s_axi_bid   = id_q;
  assign s_axi_bresp = err_q ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY;
  assign s_axi_rid   = id_q;
  assign s_axi_rdata = rdata_q;
  assign s_axi_rresp = err_q ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY;
  assign s_axi_rlast = (count == len_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      last_wr      <= 1'b0;
      count        <= '0;
      s_axi_wready <= 1'b0;
      s_axi_bvalid <= 1'b0;
      s_axi_rvalid <= 1'b0;
      sram_req     <= 1'b0;
    end else begin
      sram_req <= 1'b0;
      case (state)
        ST_IDLE: begin
          count <= '0;
          if (aw_xfer) begin
            last_wr      <= 1'b1;
            s_axi_wready <= 1'b1;
            state        <= ST_WR_BEAT;
          end else if (ar_xfer) begin
            last_wr <= 1'b0;
            state   <= ST_RD_ISSUE;
          end
        end
        ST_WR_BEAT: begin
          if (w_xfer) begin
            if (!err_q) begin
              s_axi_wready <= 1'b0;
              sram_req     <= 1'b1;
              state        <= ST_WR_WAIT;
            end else if (w_last) begin
              s_axi_wready <= 1'b0;
              s_axi_bvalid <= 1'b1;
              state        <= ST_WR_RESP;
            end else begin
              // Bad size, drain the beat without touching memory
              count <= count + 8'd1;
            end
          end
        end
        ST_WR_WAIT: begin
          if (sram_done) begin
            if (last_q) begin
              s_axi_bvalid <= 1'b1;
              state        <= ST_WR_RESP;
            end else begin
              count        <= count + 8'd1;
              s_axi_wready <= 1'b1;
              state        <= ST_WR_BEAT;
            end
          end
        end
        ST_WR_RESP: begin
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            state        <= ST_IDLE;
          end
        end
        ST_RD_ISSUE: begin
          if (err_q) begin
            s_axi_rvalid <= 1'b1;
            state        <= ST_RD_DATA;
          end else begin
            sram_req <= 1'b1;
            state    <= ST_RD_WAIT;
          end
        end
        ST_RD_WAIT: begin
          if (sram_done) begin
            s_axi_rvalid <= 1'b1;
            state        <= ST_RD_DATA;
          end
        end
        ST_RD_DATA: begin
          if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            if (count == len_q) begin
              state <= ST_IDLE;
            end else begin
              count <= count + 8'd1;
              state <= ST_RD_ISSUE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Burst attributes and SRAM request payload
  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      id_q  <= s_axi_awid;
      len_q <= s_axi_awlen;
      err_q <= s_axi_awsize > 3'(LSB);
    end else if (ar_xfer) begin
      id_q  <= s_axi_arid;
      len_q <= s_axi_arlen;
      err_q <= s_axi_arsize > 3'(LSB);
    end
    if (w_xfer) begin
      last_q     <= w_last;
      sram_we    <= 1'b1;
      sram_addr  <= wr_word_addr;
      sram_wdata <= s_axi_wdata;
      sram_be    <= s_axi_wstrb;
    end
    if (state == ST_RD_ISSUE) begin
      sram_we   <= 1'b0;
      sram_addr <= rd_word_addr;
      sram_be   <= '1;
      if (err_q) begin
        rdata_q <= '0;
      end
    end
    if (state == ST_RD_WAIT && sram_done) begin
      rdata_q <= sram_rdata;
    end
  end

endmodule

// ==== src/sram_io.sv ====
`timescale 1ns/10ps
`include "axi_sram_defines.svh"

module sram_io (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req,
  input  logic                          we,
  input  logic [`SRAM_ADDR_WIDTH-1:0]   addr,
  input  logic [`AXI_DATA_WIDTH-1:0]    wdata,
  input  logic [`AXI_STRB_WIDTH-1:0]    be,
  output logic                          done,
  output logic [`AXI_DATA_WIDTH-1:0]    rdata,

  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_addr,
  output logic                          sram_ce_n,
  output logic                          sram_oe_n,
  output logic                          sram_we_n,
  output logic [`AXI_STRB_WIDTH-1:0]    sram_be_n,
  output logic [`AXI_DATA_WIDTH-1:0]    sram_dq_out,
  output logic                          sram_dq_oe,
  input  logic [`AXI_DATA_WIDTH-1:0]    sram_dq_in
);

  axi_sram_pkg::sram_phase_e phase;
  logic                      we_q;

  // Chip select, byte enables and data driver frame the strobe by one cycle each side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase      <= axi_sram_pkg::IO_IDLE;
      done       <= 1'b0;
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      sram_be_n  <= '1;
      sram_dq_oe <= 1'b0;
    end else begin
      done <= 1'b0;
      case (phase)
        axi_sram_pkg::IO_IDLE: begin
          if (req) begin
            sram_ce_n  <= 1'b0;
            sram_be_n  <= ~be;
            sram_dq_oe <= we;
            phase      <= axi_sram_pkg::IO_SETUP;
          end
        end
        axi_sram_pkg::IO_SETUP: begin
          sram_we_n <= ~we_q;
          sram_oe_n <= we_q;
          phase     <= axi_sram_pkg::IO_STROBE;
        end
        axi_sram_pkg::IO_STROBE: begin
          // Rising strobe ends the access
          sram_we_n <= 1'b1;
          sram_oe_n <= 1'b1;
          done      <= 1'b1;
          phase     <= axi_sram_pkg::IO_RECOVER;
        end
        default: begin
          sram_ce_n  <= 1'b1;
          sram_be_n  <= '1;
          sram_dq_oe <= 1'b0;
          phase      <= axi_sram_pkg::IO_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == axi_sram_pkg::IO_IDLE && req) begin
      we_q        <= we;
      sram_addr   <= addr;
      sram_dq_out <= wdata;
    end
    // Sample on the closing edge of the read strobe
    if (phase == axi_sram_pkg::IO_STROBE && !we_q) begin
      rdata <= sram_dq_in;
    end
  end

endmodule

// ==== src/axi_sram.sv ====
`timescale 1ns/10ps
`include "axi_sram_defines.svh"

module axi_sram (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          s_axi_awvalid,
  input  logic [`AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  logic [`AXI_ID_WIDTH-1:0]      s_axi_awid,
  input  logic [7:0]                    s_axi_awlen,
  input  logic [2:0]                    s_axi_awsize,
  input  logic [1:0]                    s_axi_awburst,
  output logic                          s_axi_awready,
  input  logic                          s_axi_wvalid,
  input  logic [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
  input  logic [`AXI_STRB_WIDTH-1:0]    s_axi_wstrb,
  input  logic                          s_axi_wlast,
  output logic                          s_axi_wready,
  output logic                          s_axi_bvalid,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_bid,
  output logic [1:0]                    s_axi_bresp,
  input  logic                          s_axi_bready,

  input  logic                          s_axi_arvalid,
  input  logic [`AXI_ID_WIDTH-1:0]      s_axi_arid,
  input  logic [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
  input  logic [7:0]                    s_axi_arlen,
  input  logic [2:0]                    s_axi_arsize,
  input  logic [1:0]                    s_axi_arburst,
  output logic                          s_axi_arready,
  output logic                          s_axi_rvalid,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_rid,
  output logic [`AXI_DATA_WIDTH-1:0]    s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rlast,
  input  logic                          s_axi_rready,

  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_addr,
  output logic                          sram_ce_n,
  output logic                          sram_oe_n,
  output logic                          sram_we_n,
  output logic [`AXI_STRB_WIDTH-1:0]    sram_be_n,
  output logic [`AXI_DATA_WIDTH-1:0]    sram_dq_out,
  output logic                          sram_dq_oe,
  input  logic [`AXI_DATA_WIDTH-1:0]    sram_dq_in
);

  logic                         wr_load;
  logic                         wr_next;
  logic [`SRAM_ADDR_WIDTH-1:0]  wr_word_addr;
  logic                         rd_load;
  logic                         rd_next;
  logic [`SRAM_ADDR_WIDTH-1:0]  rd_word_addr;
  logic                         io_req;
  logic                         io_we;
  logic [`SRAM_ADDR_WIDTH-1:0]  io_addr;
  logic [`AXI_DATA_WIDTH-1:0]   io_wdata;
  logic [`AXI_STRB_WIDTH-1:0]   io_be;
  logic                         io_done;
  logic [`AXI_DATA_WIDTH-1:0]   io_rdata;

  axi_sram_ctrl axi_sram_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awid   (s_axi_awid),
    .s_axi_awlen  (s_axi_awlen),
    .s_axi_awsize (s_axi_awsize),
    .s_axi_awready(s_axi_awready),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_wlast  (s_axi_wlast),
    .s_axi_wready (s_axi_wready),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bid    (s_axi_bid),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_bready (s_axi_bready),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arid   (s_axi_arid),
    .s_axi_arlen  (s_axi_arlen),
    .s_axi_arsize (s_axi_arsize),
    .s_axi_arready(s_axi_arready),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rid    (s_axi_rid),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rlast  (s_axi_rlast),
    .s_axi_rready (s_axi_rready),
    .wr_load      (wr_load),
    .wr_next      (wr_next),
    .wr_word_addr (wr_word_addr),
    .rd_load      (rd_load),
    .rd_next      (rd_next),
    .rd_word_addr (rd_word_addr),
    .sram_req     (io_req),
    .sram_we      (io_we),
    .sram_addr    (io_addr),
    .sram_wdata   (io_wdata),
    .sram_be      (io_be),
    .sram_done    (io_done),
    .sram_rdata   (io_rdata)
  );

  // Address generators take the burst fields straight off the address channels
  axi_burst_addr wr_addr_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (wr_load),
    .next      (wr_next),
    .start_addr(s_axi_awaddr),
    .len       (s_axi_awlen),
    .size      (s_axi_awsize),
    .burst     (axi_sram_pkg::axi_burst_e'(s_axi_awburst)),
    .word_addr (wr_word_addr)
  );

  axi_burst_addr rd_addr_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (rd_load),
    .next      (rd_next),
    .start_addr(s_axi_araddr),
    .len       (s_axi_arlen),
    .size      (s_axi_arsize),
    .burst     (axi_sram_pkg::axi_burst_e'(s_axi_arburst)),
    .word_addr (rd_word_addr)
  );

  sram_io sram_io_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (io_req),
    .we         (io_we),
    .addr       (io_addr),
    .wdata      (io_wdata),
    .be         (io_be),
    .done       (io_done),
    .rdata      (io_rdata),
    .sram_addr  (sram_addr),
    .sram_ce_n  (sram_ce_n),
    .sram_oe_n  (sram_oe_n),
    .sram_we_n  (sram_we_n),
    .sram_be_n  (sram_be_n),
    .sram_dq_out(sram_dq_out),
    .sram_dq_oe (sram_dq_oe),
    .sram_dq_in (sram_dq_in)
  );

endmodule

// ==== testbench/sram_model.sv ====
`timescale 1ns/10ps
`include "axi_sram_defines.svh"

module sram_model (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`SRAM_ADDR_WIDTH-1:0]   sram_addr,
  input  logic                          sram_ce_n,
  input  logic                          sram_oe_n,
  input  logic                          sram_we_n,
  input  logic [`AXI_STRB_WIDTH-1:0]    sram_be_n,
  input  logic [`AXI_DATA_WIDTH-1:0]    sram_dq_out,
  input  logic                          sram_dq_oe,
  output logic [`AXI_DATA_WIDTH-1:0]    sram_dq_in
);

  localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

  logic [`AXI_DATA_WIDTH-1:0] mem [0:DEPTH-1];
  logic [`AXI_DATA_WIDTH-1:0] word;

  // Power-up contents follow the word address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 16'(i) ^ 16'hc3a5;
    end
  end

  assign word = mem[sram_addr];

  // Driver wins while enabled, otherwise the array answers when output is enabled
  always_comb begin
    if (sram_dq_oe) begin
      sram_dq_in = sram_dq_out;
    end else if (!sram_ce_n && !sram_oe_n) begin
      sram_dq_in[7:0]  = sram_be_n[0] ? 8'hff : word[7:0];
      sram_dq_in[15:8] = sram_be_n[1] ? 8'hff : word[15:8];
    end else begin
      sram_dq_in = 16'hffff;
    end
  end

  // Write strobe sampled once per access on the clock edge
  always @(posedge clk) begin
    if (rst_n && !sram_ce_n && !sram_we_n && sram_dq_oe) begin
      if (!sram_be_n[0]) mem[sram_addr][7:0] = sram_dq_out[7:0];
      if (!sram_be_n[1]) mem[sram_addr][15:8] = sram_dq_out[15:8];
    end
  end

endmodule

// ==== testbench/axi_sram_tb.sv ====
`timescale 1ns/10ps
`include "axi_sram_defines.svh"

module axi_sram_tb;

  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;
  localparam logic [1:0] FIXED  = 2'b00;
  localparam logic [1:0] INCR   = 2'b01;
  localparam logic [1:0] WRAP   = 2'b10;
  localparam int OP_WR    = 0;
  localparam int OP_RD    = 1;
  localparam int OP_WR_RD = 2;

  logic clk;
  logic rst_n;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wlast, s_axi_wready;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic s_axi_rvalid, s_axi_rlast, s_axi_rready;
  logic [15:0] s_axi_awaddr, s_axi_araddr, s_axi_wdata, s_axi_rdata;
  logic [3:0]  s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
  logic [7:0]  s_axi_awlen, s_axi_arlen;
  logic [2:0]  s_axi_awsize, s_axi_arsize;
  logic [1:0]  s_axi_awburst, s_axi_arburst, s_axi_wstrb, s_axi_bresp, s_axi_rresp;
  logic [14:0] sram_addr;
  logic        sram_ce_n, sram_oe_n, sram_we_n, sram_dq_oe;
  logic [1:0]  sram_be_n;
  logic [15:0] sram_dq_out, sram_dq_in;

  // Transaction table
  int          n_entries;
  int          op_t [0:15];
  logic [3:0]  id_t [0:15];
  logic [15:0] addr_t [0:15];
  logic [7:0]  len_t [0:15];
  logic [2:0]  size_t [0:15];
  logic [1:0]  burst_t [0:15];
  logic [1:0]  strb_t [0:15];
  logic [15:0] base_t [0:15];
  logic [1:0]  resp_t [0:15];

  logic [7:0]  ref_mem [0:65535];
  logic [31:0] lfsr_state;
  int          error_count;
  int          check_count;
  int          cycles;
  int          cycle_limit;
  int          total_beats;
  int          idx;

  axi_sram axi_sram_i (.*);

  sram_model sram_model_i (
    .clk(clk), .rst_n(rst_n), .sram_addr(sram_addr), .sram_ce_n(sram_ce_n),
    .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n), .sram_be_n(sram_be_n),
    .sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe), .sram_dq_in(sram_dq_in)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // Low on about one cycle in four
  function automatic logic ready_draw();
    logic b0;
    logic b1;
    b0 = lfsr_bit();
    b1 = lfsr_bit();
    return b0 | b1;
  endfunction

  // Wrapping bursts fall back to the base of the window aligned to the burst size
  function automatic logic [15:0] beat_next(input logic [15:0] a, input logic [7:0] len,
                                            input logic [2:0] size, input logic [1:0] burst);
    int bytes;
    int window;
    int lower;
    int nxt;
    bytes  = 1 << size;
    window = bytes * (int'(len) + 1);
    lower  = (int'(a) / window) * window;
    nxt    = int'(a) + bytes;
    if (burst == FIXED) begin
      nxt = int'(a);
    end else if (burst == WRAP && nxt >= lower + window) begin
      nxt = lower;
    end
    return 16'(nxt);
  endfunction

  function automatic logic [15:0] ref_word(input logic [15:0] a);
    return {ref_mem[{a[15:1], 1'b1}], ref_mem[{a[15:1], 1'b0}]};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_entry(input int op, input logic [3:0] id, input logic [15:0] addr,
                           input logic [7:0] len, input logic [2:0] size,
                           input logic [1:0] burst, input logic [1:0] strb,
                           input logic [15:0] base, input logic [1:0] resp);
    op_t[n_entries]    = op;
    id_t[n_entries]    = id;
    addr_t[n_entries]  = addr;
    len_t[n_entries]   = len;
    size_t[n_entries]  = size;
    burst_t[n_entries] = burst;
    strb_t[n_entries]  = strb;
    base_t[n_entries]  = base;
    resp_t[n_entries]  = resp;
    total_beats        = total_beats + int'(len) + 1;
    n_entries++;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic write_burst(input int e);
    logic [15:0] a;
    logic [15:0] d;
    a = addr_t[e];
    s_axi_awvalid = 1'b1;
    s_axi_awid    = id_t[e];
    s_axi_awaddr  = addr_t[e];
    s_axi_awlen   = len_t[e];
    s_axi_awsize  = size_t[e];
    s_axi_awburst = burst_t[e];
    forever begin
      @(negedge clk);
      if (s_axi_awready) break;
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b0;
    for (int b = 0; b <= int'(len_t[e]); b++) begin
      d = base_t[e] + 16'(b);
      s_axi_wvalid = 1'b1;
      s_axi_wdata  = d;
      s_axi_wstrb  = strb_t[e];
      s_axi_wlast  = (b == int'(len_t[e]));
      forever begin
        @(negedge clk);
        if (s_axi_wready) break;
        @(posedge clk);
        #1;
      end
      if (resp_t[e] == OKAY) begin
        if (strb_t[e][0]) ref_mem[{a[15:1], 1'b0}] = d[7:0];
        if (strb_t[e][1]) ref_mem[{a[15:1], 1'b1}] = d[15:8];
      end
      a = beat_next(a, len_t[e], size_t[e], burst_t[e]);
      @(posedge clk);
      #1;
      s_axi_wvalid = 1'b0;
      s_axi_wlast  = 1'b0;
    end
    forever begin
      s_axi_bready = ready_draw();
      @(negedge clk);
      if (s_axi_bvalid && s_axi_bready) break;
      @(posedge clk);
      #1;
    end
    check_eq("s_axi_bid", 32'(s_axi_bid), 32'(id_t[e]));
    check_eq("s_axi_bresp", 32'(s_axi_bresp), 32'(resp_t[e]));
    @(posedge clk);
    #1;
    s_axi_bready = 1'b0;
    check_eq("s_axi_bvalid", 32'(s_axi_bvalid), 32'd0);
  endtask

  task automatic read_burst(input int e);
    logic [15:0] a;
    logic [15:0] exp;
    int          beat;
    a = addr_t[e];
    beat = 0;
    s_axi_arvalid = 1'b1;
    s_axi_arid    = id_t[e];
    s_axi_araddr  = addr_t[e];
    s_axi_arlen   = len_t[e];
    s_axi_arsize  = size_t[e];
    s_axi_arburst = burst_t[e];
    forever begin
      @(negedge clk);
      if (s_axi_arready) break;
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b0;
    while (beat <= int'(len_t[e])) begin
      s_axi_rready = ready_draw();
      @(negedge clk);
      if (s_axi_rvalid && s_axi_rready) begin
        exp = (resp_t[e] == OKAY) ? ref_word(a) : 16'h0000;
        check_eq("s_axi_rdata", 32'(s_axi_rdata), 32'(exp));
        check_eq("s_axi_rid", 32'(s_axi_rid), 32'(id_t[e]));
        check_eq("s_axi_rresp", 32'(s_axi_rresp), 32'(resp_t[e]));
        check_eq("s_axi_rlast", 32'(s_axi_rlast), 32'(beat == int'(len_t[e])));
        a = beat_next(a, len_t[e], size_t[e], burst_t[e]);
        beat++;
      end
      @(posedge clk);
      #1;
    end
    s_axi_rready = 1'b0;
    check_eq("s_axi_rvalid", 32'(s_axi_rvalid), 32'd0);
  endtask

  initial begin
    lfsr_state  = 32'h389943c2;
    error_count = 0;
    check_count = 0;
    cycles      = 0;
    cycle_limit = 0;
    total_beats = 0;
    n_entries   = 0;
    rst_n = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awid    = '0;
    s_axi_awlen   = '0;
    s_axi_awsize  = '0;
    s_axi_awburst = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wlast   = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arid    = '0;
    s_axi_arlen   = '0;
    s_axi_arsize  = '0;
    s_axi_arburst = '0;
    s_axi_rready  = 1'b0;
    for (int w = 0; w < 32768; w++) begin
      ref_mem[2 * w]     = 8'(16'(w) ^ 16'hc3a5);
      ref_mem[2 * w + 1] = 8'((16'(w) ^ 16'hc3a5) >> 8);
    end

    add_entry(OP_WR,    4'hd, 16'ha000, 8'd3, 3'd1, INCR,  2'b11, 16'h1000, OKAY);
    add_entry(OP_RD,    4'hd, 16'ha000, 8'd3, 3'd1, INCR,  2'b11, 16'h0000, OKAY);
    add_entry(OP_WR,    4'h3, 16'ha000, 8'd3, 3'd1, INCR,  2'b01, 16'h2200, OKAY);
    add_entry(OP_RD,    4'h3, 16'ha000, 8'd3, 3'd1, INCR,  2'b11, 16'h0000, OKAY);
    add_entry(OP_WR,    4'h5, 16'hb000, 8'd3, 3'd1, FIXED, 2'b11, 16'h3300, OKAY);
    add_entry(OP_RD,    4'h5, 16'hb000, 8'd1, 3'd1, FIXED, 2'b11, 16'h0000, OKAY);
    // Wrap window of 8 bytes entered halfway
    add_entry(OP_WR,    4'h6, 16'hc004, 8'd3, 3'd1, WRAP,  2'b11, 16'h4400, OKAY);
    add_entry(OP_RD,    4'h6, 16'hc000, 8'd3, 3'd1, INCR,  2'b11, 16'h0000, OKAY);
    add_entry(OP_RD,    4'h7, 16'hc006, 8'd3, 3'd1, WRAP,  2'b11, 16'h0000, OKAY);
    add_entry(OP_WR,    4'h9, 16'ha000, 8'd1, 3'd2, INCR,  2'b11, 16'h5500, SLVERR);
    add_entry(OP_RD,    4'h9, 16'ha000, 8'd1, 3'd2, INCR,  2'b11, 16'h0000, SLVERR);
    add_entry(OP_RD,    4'ha, 16'ha000, 8'd3, 3'd1, INCR,  2'b11, 16'h0000, OKAY);
    // Write and read launched together on disjoint regions
    add_entry(OP_WR_RD, 4'hb, 16'hd000, 8'd7, 3'd1, INCR,  2'b11, 16'h6600, OKAY);
    add_entry(OP_RD,    4'hc, 16'ha000, 8'd3, 3'd1, INCR,  2'b11, 16'h0000, OKAY);
    add_entry(OP_RD,    4'hb, 16'hd000, 8'd7, 3'd1, INCR,  2'b11, 16'h0000, OKAY);
    cycle_limit = total_beats * 16 + 200;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("s_axi_bvalid", 32'(s_axi_bvalid), 32'd0);
    check_eq("s_axi_rvalid", 32'(s_axi_rvalid), 32'd0);
    check_eq("s_axi_wready", 32'(s_axi_wready), 32'd0);
    check_eq("s_axi_awready", 32'(s_axi_awready), 32'd0);
    check_eq("s_axi_arready", 32'(s_axi_arready), 32'd0);
    check_eq("sram_ce_n", 32'(sram_ce_n), 32'd1);
    check_eq("sram_oe_n", 32'(sram_oe_n), 32'd1);
    check_eq("sram_we_n", 32'(sram_we_n), 32'd1);
    check_eq("sram_be_n", 32'(sram_be_n), 32'd3);
    check_eq("sram_dq_oe", 32'(sram_dq_oe), 32'd0);
    @(posedge clk);
    #1;

    idx = 0;
    while (idx < n_entries) begin
      if (op_t[idx] == OP_WR) begin
        write_burst(idx);
        idx = idx + 1;
      end else if (op_t[idx] == OP_RD) begin
        read_burst(idx);
        idx = idx + 1;
      end else begin
        fork
          write_burst(idx);
          read_burst(idx + 1);
        join
        idx = idx + 2;
      end
    end

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+src
src/axi_sram_pkg.sv
src/axi_burst_addr.sv
src/axi_sram_ctrl.sv
src/sram_io.sv
src/axi_sram.sv
testbench/sram_model.sv
testbench/axi_sram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module axi_sram_tb \
  -o axi_sram_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/axi_sram_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
